// File: run_sim.sh
#!/bin/sh
# build and run the osd video testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_osd_video -o tb_osd_video_sim
./obj_dir/tb_osd_video_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Verification passed" sim.log
echo "simulation passed"

// File: sim.f
src/osd_pkg.sv
src/vga_timing.sv
src/spi_osd_slave.sv
src/osd_char_overlay.sv
src/tmds_encoder.sv
src/osd_video_top.sv
tests/tb_osd_video.sv
tests/osd_video_assert.sv

// File: src/osd_char_overlay.sv
`timescale 1ns/10ps
module osd_char_overlay
#(
  parameter int TEXT_COLS = 80,
  parameter int TEXT_ROWS = 60
)
(
  input  logic               i_clk_pixel,
  input  logic               i_rst_n,
  input  osd_pkg::video_t    i_video,
  input  logic [10:0]        i_x,
  input  logic [10:0]        i_y,
  input  osd_pkg::mem_wr_t   i_wr,
  input  osd_pkg::osd_ctrl_t i_ctrl,
  output osd_pkg::video_t    o_video
);
  import osd_pkg::*;

  localparam int CHAR_DEPTH = TEXT_COLS * TEXT_ROWS;
  localparam int CHAR_AW    = $clog2(CHAR_DEPTH);
  localparam int FONT_DEPTH = 256 * CELL_H;
  localparam int FONT_AW    = $clog2(FONT_DEPTH);

  logic [7:0]  char_ram [CHAR_DEPTH];
  logic [7:0]  font_ram [FONT_DEPTH];

  logic [7:0]  cell_col;
  logic [7:0]  cell_row;
  logic [15:0] char_idx;
  logic        in_grid;

  logic [7:0]  s1_code;
  logic [2:0]  s1_ypix;
  logic [2:0]  s1_xpix;
  logic        s1_in_grid;
  video_t      s1_video;

  logic [7:0]  s2_glyph;
  logic [2:0]  s2_xpix;
  logic        s2_in_grid;
  video_t      s2_video;

  logic        pix_on;
  video_t      mix;

  assign cell_col = 8'(i_x / 11'(CELL_W));
  assign cell_row = 8'(i_y / 11'(CELL_H));
  assign in_grid  = (cell_col < 8'(TEXT_COLS)) && (cell_row < 8'(TEXT_ROWS));
  assign char_idx = 16'(cell_row * TEXT_COLS) + 16'(cell_col);

  // stage 1, character code
  always_ff @(posedge i_clk_pixel)
  begin
    if (i_wr.valid && i_wr.target == TGT_CHAR && i_wr.addr < 16'(CHAR_DEPTH))
      char_ram[i_wr.addr[CHAR_AW-1:0]] <= i_wr.data;
    s1_code    <= char_ram[char_idx[CHAR_AW-1:0]];
    s1_ypix    <= 3'(i_y % 11'(CELL_H));
    s1_xpix    <= 3'(i_x % 11'(CELL_W));
    s1_in_grid <= in_grid;  // off-grid reads are masked later
  end

  // stage 2, glyph row
  always_ff @(posedge i_clk_pixel)
  begin
    if (i_wr.valid && i_wr.target == TGT_FONT && i_wr.addr < 16'(FONT_DEPTH))
      font_ram[i_wr.addr[FONT_AW-1:0]] <= i_wr.data;
    s2_glyph   <= font_ram[{s1_code, s1_ypix}];
    s2_xpix    <= s1_xpix;
    s2_in_grid <= s1_in_grid;
  end

  assign pix_on = s2_in_grid & s2_glyph[3'd7 - s2_xpix];  // bit 7 is leftmost

  always_comb
  begin
    mix = s2_video;
    if (i_ctrl.enable && !s2_video.blank)
    begin
      if (pix_on)
      begin
        mix.r = {8{i_ctrl.fg_colour[2]}};
        mix.g = {8{i_ctrl.fg_colour[1]}};
        mix.b = {8{i_ctrl.fg_colour[0]}};
      end
      else if (i_ctrl.transparent)
      begin
        // background dimmed to half
        mix.r = {1'b0, s2_video.r[7:1]};
        mix.g = {1'b0, s2_video.g[7:1]};
        mix.b = {1'b0, s2_video.b[7:1]};
      end
      else
      begin
        mix.r = 8'h00;
        mix.g = 8'h00;
        mix.b = 8'h00;
      end
    end
  end

  // syncs and blank ride along with the lookup
  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      s1_video <= VIDEO_RESET;
      s2_video <= VIDEO_RESET;
      o_video  <= VIDEO_RESET;
    end
    else
    begin
      s1_video <= i_video;
      s2_video <= s1_video;
      o_video  <= mix;  // stage 3
    end
  end

endmodule

// File: src/osd_pkg.sv
package osd_pkg;

  // glyph cell size, font RAM is laid out as code*CELL_H + row
  localparam int CELL_W = 8;
  localparam int CELL_H = 8;

  // one pixel of parallel video
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hsync;  // active high
    logic       vsync;  // active high
    logic       blank;
  } video_t;

  localparam video_t VIDEO_RESET = '{r: 8'h00, g: 8'h00, b: 8'h00,
                                     hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

  typedef struct packed {
    logic [9:0] red;
    logic [9:0] green;
    logic [9:0] blue;
  } tmds_t;

  // DVI control symbols, indexed by {c1, c0}
  localparam logic [9:0] TMDS_CTRL [4] = '{10'b1101010100, 10'b0010101011,
                                           10'b0101010100, 10'b1010101011};

  typedef struct packed {
    logic       enable;
    logic       transparent;
    logic [2:0] fg_colour;  // r g b
    logic [2:0] rsvd;
  } osd_ctrl_t;

  localparam logic TGT_CHAR = 1'b0;
  localparam logic TGT_FONT = 1'b1;

  typedef struct packed {
    logic        valid;
    logic        target;  // TGT_CHAR or TGT_FONT
    logic [15:0] addr;
    logic [7:0]  data;
  } mem_wr_t;

  typedef enum logic [7:0] {
    OP_WRITE_CHAR = 8'd1,
    OP_WRITE_FONT = 8'd2,
    OP_SET_CTRL   = 8'd3
  } osd_opcode_e;

  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_DATA,
    ST_IGNORE
  } spi_state_e;

endpackage

// File: src/osd_video_top.sv
`timescale 1ns/10ps
module osd_video_top
#(
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int TEXT_COLS = H_ACTIVE / osd_pkg::CELL_W,
  parameter int TEXT_ROWS = V_ACTIVE / osd_pkg::CELL_H
)
(
  input  logic            i_clk_pixel,
  input  logic            i_rst_n,
  input  logic            i_spi_csn,
  input  logic            i_spi_sclk,
  input  logic            i_spi_mosi,
  output osd_pkg::video_t o_vga,
  output osd_pkg::tmds_t  o_tmds
);
  import osd_pkg::*;

  video_t      timing_video;
  logic [10:0] timing_x;
  logic [10:0] timing_y;
  mem_wr_t     osd_wr;
  osd_ctrl_t   osd_ctrl;

  // test picture source
  vga_timing
  #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  )
  vga_timing_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n),
    .o_video(timing_video), .o_x(timing_x), .o_y(timing_y)
  );

  // host writes text, font and control
  spi_osd_slave spi_osd_slave_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n),
    .i_spi_csn(i_spi_csn), .i_spi_sclk(i_spi_sclk), .i_spi_mosi(i_spi_mosi),
    .o_wr(osd_wr), .o_ctrl(osd_ctrl)
  );

  osd_char_overlay
  #(
    .TEXT_COLS(TEXT_COLS),
    .TEXT_ROWS(TEXT_ROWS)
  )
  osd_char_overlay_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n),
    .i_video(timing_video), .i_x(timing_x), .i_y(timing_y),
    .i_wr(osd_wr), .i_ctrl(osd_ctrl), .o_video(o_vga)
  );

  // syncs go out on blue only
  tmds_encoder tmds_red_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n), .i_data(o_vga.r),
    .i_ctrl(2'b00), .i_blank(o_vga.blank), .o_symbol(o_tmds.red)
  );

  tmds_encoder tmds_green_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n), .i_data(o_vga.g),
    .i_ctrl(2'b00), .i_blank(o_vga.blank), .o_symbol(o_tmds.green)
  );

  tmds_encoder tmds_blue_inst
  (
    .i_clk_pixel(i_clk_pixel), .i_rst_n(i_rst_n), .i_data(o_vga.b),
    .i_ctrl({o_vga.vsync, o_vga.hsync}), .i_blank(o_vga.blank), .o_symbol(o_tmds.blue)
  );

endmodule

// File: src/spi_osd_slave.sv
`timescale 1ns/10ps
module spi_osd_slave
(
  input  logic               i_clk_pixel,
  input  logic               i_rst_n,
  input  logic               i_spi_csn,
  input  logic               i_spi_sclk,
  input  logic               i_spi_mosi,
  output osd_pkg::mem_wr_t   o_wr,
  output osd_pkg::osd_ctrl_t o_ctrl
);
  import osd_pkg::*;

  logic [1:0]  csn_sync;
  logic [1:0]  sclk_sync;
  logic [1:0]  mosi_sync;
  logic        sclk_prev;
  logic        sclk_rise;
  logic [2:0]  bit_cnt;
  logic [6:0]  shift_q;
  logic [7:0]  rx_byte;
  logic        byte_done;
  spi_state_e  state_q;
  osd_opcode_e op_q;
  logic [15:0] addr_q;

  // two-flop synchronisers into the pixel clock domain
  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      csn_sync  <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], i_spi_csn};
      sclk_sync <= {sclk_sync[0], i_spi_sclk};
      mosi_sync <= {mosi_sync[0], i_spi_mosi};
      sclk_prev <= sclk_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev & ~csn_sync[1];
  assign rx_byte   = {shift_q, mosi_sync[1]};  // msb first
  assign byte_done = sclk_rise && (bit_cnt == 3'd7);

  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      bit_cnt <= 3'd0;
      shift_q <= 7'd0;
      state_q <= ST_OPCODE;
      op_q    <= OP_WRITE_CHAR;
      addr_q  <= 16'd0;
      o_wr    <= '0;
      o_ctrl  <= '0;  // osd off
    end
    else
    begin
      o_wr.valid <= 1'b0;
      if (csn_sync[1])
      begin
        // deselect aborts whatever was in flight
        state_q <= ST_OPCODE;
        bit_cnt <= 3'd0;
      end
      else if (sclk_rise)
      begin
        bit_cnt <= bit_cnt + 3'd1;
        shift_q <= rx_byte[6:0];
      end
      if (!csn_sync[1] && byte_done)
      begin
        case (state_q)
          ST_OPCODE:
          begin
            case (rx_byte)
              OP_WRITE_CHAR, OP_WRITE_FONT:
              begin
                op_q    <= osd_opcode_e'(rx_byte);
                state_q <= ST_ADDR_HI;
              end
              OP_SET_CTRL:
              begin
                op_q    <= OP_SET_CTRL;
                state_q <= ST_DATA;
              end
              default: state_q <= ST_IGNORE;  // unknown opcode
            endcase
          end
          ST_ADDR_HI:
          begin
            addr_q[15:8] <= rx_byte;
            state_q      <= ST_ADDR_LO;
          end
          ST_ADDR_LO:
          begin
            addr_q[7:0] <= rx_byte;
            state_q     <= ST_DATA;
          end
          ST_DATA:
          begin
            if (op_q == OP_SET_CTRL)
            begin
              o_ctrl  <= osd_ctrl_t'(rx_byte);
              state_q <= ST_IGNORE;  // rest of the burst dropped
            end
            else
            begin
              o_wr.valid  <= 1'b1;
              o_wr.target <= (op_q == OP_WRITE_FONT) ? TGT_FONT : TGT_CHAR;
              o_wr.addr   <= addr_q;
              o_wr.data   <= rx_byte;
              addr_q      <= addr_q + 16'd1;  // burst auto increment
            end
          end
          default: state_q <= ST_IGNORE;
        endcase
      end
    end
  end

endmodule

// File: src/tmds_encoder.sv
`timescale 1ns/10ps
module tmds_encoder
(
  input  logic       i_clk_pixel,
  input  logic       i_rst_n,
  input  logic [7:0] i_data,
  input  logic [1:0] i_ctrl,
  input  logic       i_blank,
  output logic [9:0] o_symbol
);
  import osd_pkg::*;

  logic [3:0]        n1_data;
  logic              use_xnor;
  logic [8:0]        q_m;
  logic [3:0]        n1_qm;
  logic signed [4:0] diff_qm;  // ones minus zeros in q_m[7:0]
  logic signed [4:0] disp_q;
  logic signed [4:0] disp_d;
  logic [9:0]        sym_d;

  function automatic logic [3:0] count_ones(input logic [7:0] v);
    logic [3:0] n;
    n = 4'd0;
    for (int i = 0; i < 8; i++)
      n = n + {3'b000, v[i]};
    return n;
  endfunction

  assign n1_data  = count_ones(i_data);
  assign use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !i_data[0]);

  // transition minimising stage
  always_comb
  begin
    q_m[0] = i_data[0];
    for (int i = 1; i < 8; i++)
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
    q_m[8] = ~use_xnor;
  end

  assign n1_qm   = count_ones(q_m[7:0]);
  assign diff_qm = $signed({1'b0, n1_qm}) - $signed({1'b0, 4'd8 - n1_qm});

  // dc balance, invert when it pulls disparity back toward zero
  always_comb
  begin
    if (disp_q == 5'sd0 || diff_qm == 5'sd0)
    begin
      sym_d  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_d = q_m[8] ? disp_q + diff_qm : disp_q - diff_qm;
    end
    else if ((disp_q > 0 && diff_qm > 0) || (disp_q < 0 && diff_qm < 0))
    begin
      sym_d  = {1'b1, q_m[8], ~q_m[7:0]};
      disp_d = disp_q - diff_qm + (q_m[8] ? 5'sd2 : 5'sd0);
    end
    else
    begin
      sym_d  = {1'b0, q_m[8], q_m[7:0]};
      disp_d = disp_q + diff_qm - (q_m[8] ? 5'sd0 : 5'sd2);
    end
  end

  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_symbol <= TMDS_CTRL[0];
      disp_q   <= 5'sd0;
    end
    else if (i_blank)
    begin
      o_symbol <= TMDS_CTRL[i_ctrl];
      disp_q   <= 5'sd0;  // balance restarts each active run
    end
    else
    begin
      o_symbol <= sym_d;
      disp_q   <= disp_d;
    end
  end

endmodule

// File: src/vga_timing.sv
`timescale 1ns/10ps
module vga_timing
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
)
(
  input  logic            i_clk_pixel,
  input  logic            i_rst_n,
  output osd_pkg::video_t o_video,
  output logic [10:0]     o_x,
  output logic [10:0]     o_y
);
  import osd_pkg::*;

  localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_ON = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_ON = V_ACTIVE + V_FRONT;

  logic [10:0] h_cnt;
  logic [10:0] v_cnt;
  logic        h_last;
  logic        active;

  assign h_last = (h_cnt == 11'(H_TOTAL - 1));
  assign active = (h_cnt < 11'(H_ACTIVE)) && (v_cnt < 11'(V_ACTIVE));

  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      h_cnt <= 11'd0;
      v_cnt <= 11'd0;
    end
    else
    begin
      h_cnt <= h_last ? 11'd0 : h_cnt + 11'd1;
      if (h_last)
      begin
        // next line, wrap after the last line of the frame
        if (v_cnt == 11'(V_TOTAL - 1))
          v_cnt <= 11'd0;
        else
          v_cnt <= v_cnt + 11'd1;
      end
    end
  end

  // pixel and its coordinates leave on the same edge
  always_ff @(posedge i_clk_pixel or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_video <= VIDEO_RESET;
      o_x     <= 11'd0;
      o_y     <= 11'd0;
    end
    else
    begin
      o_x           <= h_cnt;
      o_y           <= v_cnt;
      o_video.hsync <= (h_cnt >= 11'(H_SYNC_ON)) && (h_cnt < 11'(H_SYNC_ON + H_SYNC));
      o_video.vsync <= (v_cnt >= 11'(V_SYNC_ON)) && (v_cnt < 11'(V_SYNC_ON + V_SYNC));
      o_video.blank <= ~active;
      o_video.r     <= active ? h_cnt[7:0] : 8'h00;  // horizontal ramp
      o_video.g     <= active ? v_cnt[7:0] : 8'h00;  // vertical ramp
      o_video.b     <= active ? (h_cnt[7:0] ^ v_cnt[7:0]) : 8'h00;
    end
  end

endmodule

// File: tests/osd_video_assert.sv
`timescale 1ns/10ps
module osd_video_assert
#(
  parameter bit IS_ENC = 1'b0
)
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic signed [4:0] i_disp,
  input  logic              i_blank,
  input  logic [9:0]        i_symbol,
  input  logic [7:0]        i_ctrl,
  input  logic              i_csn
);
  logic selected;  // host has pulled csn low at least once

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      selected <= 1'b0;
    else if (!i_csn)
      selected <= 1'b1;
  end

  generate
    if (IS_ENC)
    begin : g_enc
      disparity_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_disp <= 5'sd10) && (i_disp >= -5'sd10))
        else $error("running disparity out of range");

      blank_symbols: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_blank |=> (i_symbol == 10'b1101010100) || (i_symbol == 10'b0010101011) ||
                    (i_symbol == 10'b0101010100) || (i_symbol == 10'b1010101011))
        else $error("blank symbol is not a control code");
    end
    else
    begin : g_top
      ctrl_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !selected |-> (i_ctrl == 8'h00))
        else $error("control register set before any spi access");
    end
  endgenerate

endmodule

bind tmds_encoder osd_video_assert #(.IS_ENC(1'b1)) enc_checks
(
  .i_clk(i_clk_pixel), .i_rst_n(i_rst_n), .i_disp(disp_q), .i_blank(i_blank),
  .i_symbol(o_symbol), .i_ctrl(8'h00), .i_csn(1'b1)
);

bind osd_video_top osd_video_assert #(.IS_ENC(1'b0)) top_checks
(
  .i_clk(i_clk_pixel), .i_rst_n(i_rst_n), .i_disp(5'sd0), .i_blank(1'b1),
  .i_symbol(10'd0), .i_ctrl(osd_ctrl), .i_csn(i_spi_csn)
);

// File: tests/tb_osd_video.sv
`timescale 1ns/10ps
module tb_osd_video;
  import osd_pkg::*;

  localparam int H_ACT      = 64;
  localparam int H_FP       = 4;
  localparam int H_SW       = 6;
  localparam int H_BP       = 6;
  localparam int H_TOT      = H_ACT + H_FP + H_SW + H_BP;
  localparam int V_ACT      = 32;
  localparam int V_FP       = 2;
  localparam int V_SW       = 3;
  localparam int V_BP       = 3;
  localparam int V_TOT      = V_ACT + V_FP + V_SW + V_BP;
  localparam int COLS       = 8;
  localparam int ROWS       = 4;
  localparam int FRAME      = H_TOT * V_TOT;
  localparam int MAX_CYCLES = 60000;  // ~6 frames plus ~400 spi bytes

  logic       clk;
  logic       rst_n;
  logic       spi_csn;
  logic       spi_sclk;
  logic       spi_mosi;
  video_t     vga;
  tmds_t      tmds;

  logic [7:0] char_sh [COLS*ROWS];  // shadow copies of the DUT state
  logic [7:0] font_sh [2048];
  logic [7:0] ctrl_sh;
  logic [7:0] tx_q [$];             // bytes of the next spi transaction
  bit         spi_busy;
  int         settle;
  bit         aligned;
  int         ref_h;
  int         ref_v;
  bit         prev_hsync;
  bit         prev_valid;
  video_t     prev_vga;
  bit         line_full;
  bit         frame_full;
  int         hs_len;
  int         act_len;
  int         vs_lines;
  int         act_lines;
  int         colour_checks;
  int         cycles;

  osd_video_top
  #(
    .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
    .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP),
    .TEXT_COLS(COLS), .TEXT_ROWS(ROWS)
  )
  i_dut
  (
    .i_clk_pixel(clk), .i_rst_n(rst_n),
    .i_spi_csn(spi_csn), .i_spi_sclk(spi_sclk), .i_spi_mosi(spi_mosi),
    .o_vga(vga), .o_tmds(tmds)
  );

  always #50 clk = ~clk;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected)
    begin
      $display("ERR %0t: %s got %h expected %h", $time, msg, actual, expected);
      $display("Verification failed");
      $fatal(1, "check mismatch");
    end
  endtask

  // expected pixel straight from the timing, test picture and mix rules
  function automatic video_t expected_pixel(input int h, input int v);
    video_t    px;
    osd_ctrl_t c;
    logic [7:0] code;
    logic [7:0] glyph;
    logic       on;
    c        = osd_ctrl_t'(ctrl_sh);
    px.hsync = (h >= H_ACT + H_FP) && (h < H_ACT + H_FP + H_SW);
    px.vsync = (v >= V_ACT + V_FP) && (v < V_ACT + V_FP + V_SW);
    px.blank = !((h < H_ACT) && (v < V_ACT));
    px.r     = px.blank ? 8'h00 : 8'(h);
    px.g     = px.blank ? 8'h00 : 8'(v);
    px.b     = px.blank ? 8'h00 : 8'(h ^ v);
    if (c.enable && !px.blank)
    begin
      if ((h / 8) < COLS && (v / 8) < ROWS)
      begin
        code  = char_sh[(v / 8) * COLS + h / 8];
        glyph = font_sh[int'(code) * 8 + v % 8];
        on    = glyph[7 - h % 8];  // msb is leftmost
      end
      else
        on = 1'b0;
      if (on)
      begin
        px.r = {8{c.fg_colour[2]}};
        px.g = {8{c.fg_colour[1]}};
        px.b = {8{c.fg_colour[0]}};
      end
      else if (c.transparent)
      begin
        px.r = px.r >> 1;
        px.g = px.g >> 1;
        px.b = px.b >> 1;
      end
      else
      begin
        px.r = 8'h00;
        px.g = 8'h00;
        px.b = 8'h00;
      end
    end
    return px;
  endfunction

  function automatic logic [7:0] tmds_decode(input logic [9:0] s);
    logic [7:0] q;
    logic [7:0] d;
    q    = s[9] ? ~s[7:0] : s[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++)
      d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
    return d;
  endfunction

  function automatic logic [9:0] ctrl_code(input logic [1:0] c);
    case (c)
      2'b00:   return 10'b1101010100;
      2'b01:   return 10'b0010101011;
      2'b10:   return 10'b0101010100;
      default: return 10'b1010101011;
    endcase
  endfunction

  // decode a finished transaction into the shadows
  task automatic apply_to_shadow();
    logic [15:0] addr;
    if (tx_q.size() >= 2 && tx_q[0] == 8'd3)
      ctrl_sh = tx_q[1];
    else if (tx_q.size() >= 3 && (tx_q[0] == 8'd1 || tx_q[0] == 8'd2))
    begin
      addr = {tx_q[1], tx_q[2]};
      for (int i = 3; i < tx_q.size(); i++)
      begin
        if (tx_q[0] == 8'd1 && addr < 16'(COLS * ROWS))
          char_sh[addr] = tx_q[i];
        else if (tx_q[0] == 8'd2 && addr < 16'd2048)
          font_sh[addr] = tx_q[i];
        addr = addr + 16'd1;
      end
    end
  endtask

  // mode 0 with 4 cycles per sclk phase
  task automatic spi_transfer();
    spi_busy = 1'b1;
    @(negedge clk);
    spi_csn = 1'b0;
    repeat (4) @(negedge clk);
    foreach (tx_q[i])
    begin
      for (int b = 7; b >= 0; b--)
      begin
        spi_mosi = tx_q[i][b];
        spi_sclk = 1'b0;
        repeat (4) @(negedge clk);
        spi_sclk = 1'b1;
        repeat (4) @(negedge clk);
      end
    end
    spi_sclk = 1'b0;
    repeat (4) @(negedge clk);
    spi_csn = 1'b1;
    apply_to_shadow();
    repeat (8) @(negedge clk);
    spi_busy = 1'b0;
    tx_q.delete();
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin : compare_outputs
    video_t exp_px;
    if (rst_n && !aligned && vga.hsync && !prev_hsync)
    begin
      aligned = 1'b1;  // first hsync rise is line 0 at the sync start
      ref_h   = H_ACT + H_FP;
      ref_v   = 0;
    end
    if (aligned)
    begin
      exp_px = expected_pixel(ref_h, ref_v);
      check(32'(vga.hsync), 32'(exp_px.hsync), "hsync");
      check(32'(vga.vsync), 32'(exp_px.vsync), "vsync");
      check(32'(vga.blank), 32'(exp_px.blank), "blank");
      if (settle == 0)
      begin
        check({8'h00, vga.r, vga.g, vga.b}, {8'h00, exp_px.r, exp_px.g, exp_px.b},
              $sformatf("colour at x=%0d y=%0d", ref_h, ref_v));
        colour_checks++;
      end
      if (vga.hsync)
        hs_len++;
      if (!vga.blank)
        act_len++;
      if (ref_h == H_TOT - 1)
      begin
        if (line_full)
        begin
          check(hs_len, H_SW, "hsync width");
          check(act_len, (ref_v < V_ACT) ? H_ACT : 0, "active pixels per line");
        end
        if (act_len > 0)
          act_lines++;
        if (vga.vsync)
          vs_lines++;
        line_full = 1'b1;
        hs_len    = 0;
        act_len   = 0;
        if (ref_v == V_TOT - 1)
        begin
          if (frame_full)
          begin
            check(vs_lines, V_SW, "vsync lines");
            check(act_lines, V_ACT, "active lines");
          end
          frame_full = 1'b1;
          vs_lines   = 0;
          act_lines  = 0;
        end
      end
      ref_h = (ref_h == H_TOT - 1) ? 0 : ref_h + 1;
      if (ref_h == 0)
        ref_v = (ref_v == V_TOT - 1) ? 0 : ref_v + 1;
    end
    // encoders lag o_vga by one cycle
    if (prev_valid)
    begin
      if (!prev_vga.blank)
      begin
        check(32'(tmds_decode(tmds.red)), 32'(prev_vga.r), "tmds red data");
        check(32'(tmds_decode(tmds.green)), 32'(prev_vga.g), "tmds green data");
        check(32'(tmds_decode(tmds.blue)), 32'(prev_vga.b), "tmds blue data");
      end
      else
      begin
        check(32'(tmds.blue), 32'(ctrl_code({prev_vga.vsync, prev_vga.hsync})),
              "tmds blue ctrl");
        check(32'(tmds.red), 32'(ctrl_code(2'b00)), "tmds red ctrl");
        check(32'(tmds.green), 32'(ctrl_code(2'b00)), "tmds green ctrl");
      end
    end
    prev_vga   = vga;
    prev_valid = 1'b1;
    prev_hsync = vga.hsync;
    if (spi_busy)
      settle = 12;
    else if (settle > 0)
      settle--;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  initial
  begin : main_sequence
    logic [7:0] fg;
    int         idx;
    void'($urandom(32'h4f33bec9));
    clk      = 1'b0;
    rst_n    = 1'b0;
    spi_csn  = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    ctrl_sh  = 8'h00;
    repeat (16) @(negedge clk);
    check(32'(vga), 32'h1, "reset state");  // syncs low, blank high
    rst_n = 1'b1;
    while (!aligned)
      @(negedge clk);
    repeat (2 * FRAME) @(negedge clk);  // test picture only

    tx_q = '{8'd1, 8'd0, 8'd0};
    for (int i = 0; i < COLS * ROWS; i++)
      tx_q.push_back(8'($urandom % 16));
    spi_transfer();
    tx_q = '{8'd2, 8'd0, 8'd0};
    for (int i = 0; i < 16 * 8; i++)
      tx_q.push_back(8'($urandom));
    spi_transfer();
    fg   = {1'b1, 1'b0, 3'($urandom % 7) + 3'd1, 3'b000};  // enable and opaque, never black
    tx_q = '{8'd3, fg, 8'hff};
    spi_transfer();
    tx_q = '{8'h55, 8'h00, 8'h01, 8'hff};  // unknown opcode gets dropped
    spi_transfer();
    repeat (2 * FRAME) @(negedge clk);

    fg[6] = 1'b1;  // transparent
    tx_q  = '{8'd3, fg};
    spi_transfer();
    repeat (FRAME) @(negedge clk);

    idx  = $urandom % (COLS * ROWS);
    tx_q = '{8'd1, 8'd0, 8'(idx), 8'(char_sh[idx] + 8'd1) & 8'h0f};
    spi_transfer();
    repeat (2 * FRAME) @(negedge clk);

    if (colour_checks > 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("No colour comparisons were made");
      $display("Verification failed");
      $fatal(1, "nothing checked");
    end
  end

endmodule
